/* Makefile */
.PHONY: all run clean

all: run

obj_dir/Vtb_spi_ddr_phy: project.f $(shell cat project.f)
	verilator --binary --timing --assert --top-module tb_spi_ddr_phy -f project.f

run: obj_dir/Vtb_spi_ddr_phy
	./obj_dir/Vtb_spi_ddr_phy | awk '{ print } \
		/^Simulation completed successfully$$/ { ok = 1 } \
		END { exit !ok }'

clean:
	rm -rf obj_dir

/* calib/calib_fsm.sv */
`timescale 1ns/1ps

module calib_fsm import phy_cfg_pkg::*, phy_data_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cal_start,
    input  rx_word_u   word,
    input  logic       word_valid,
    input  logic       cnt_zero,
    output logic       cnt_load,
    output logic       cnt_dec,
    output logic [7:0] cnt_value,
    output logic [3:0] cal_tap,
    output logic       cal_active,
    output logic       delay_locked,
    output logic       cal_fail
);

    logic [2:0] state;
    logic [2:0] state_next;
    logic       sweep_start;   // begin at tap 0
    logic       tap_step;      // current tap failed, try the next one
    logic       last_tap;
    logic       word_match;

    assign last_tap   = (cal_tap == 4'(tap_count - 1));
    assign word_match = (word.word == train_word);

    always_comb begin
        state_next  = state;
        sweep_start = 1'b0;
        tap_step    = 1'b0;
        cnt_load    = 1'b0;
        cnt_dec     = 1'b0;
        cnt_value   = 8'(settle_cycles);
        case (state)
            st_idle, st_locked, st_failed: begin
                // new sweep also drops an old lock or failure
                if (cal_start) begin
                    sweep_start = 1'b1;
                    cnt_load    = 1'b1;
                    state_next  = st_settle;
                end
            end
            st_settle: begin
                if (cnt_zero) begin
                    cnt_load   = 1'b1;
                    cnt_value  = 8'(compare_words);  // window now counts words
                    state_next = st_compare;
                end else begin
                    cnt_dec = 1'b1;
                end
            end
            st_compare: begin
                if (cnt_zero) begin
                    state_next = st_locked;  // enough clean words in a row
                end else if (word_valid) begin
                    if (word_match) begin
                        cnt_dec = 1'b1;
                    end else if (last_tap) begin
                        state_next = st_failed;
                    end else begin
                        tap_step   = 1'b1;
                        cnt_load   = 1'b1;
                        state_next = st_settle;
                    end
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            cal_tap <= 4'd0;
        end else begin
            state <= state_next;
            if (sweep_start) begin
                cal_tap <= 4'd0;
            end else if (tap_step) begin
                cal_tap <= cal_tap + 4'd1;
            end
        end
    end

    // tap stays owned by calibration while locked
    assign cal_active   = (state == st_settle) || (state == st_compare) ||
                          (state == st_locked);
    assign delay_locked = (state == st_locked);
    assign cal_fail     = (state == st_failed);

endmodule

/* calib/train_counter.sv */
`timescale 1ns/1ps

module train_counter (
    input  logic       clk,
    input  logic       rst,
    input  logic       load,
    input  logic [7:0] value,
    input  logic       dec,
    output logic       zero
);

    logic [7:0] count;

    assign zero = (count == 8'd0);

    // load wins over dec, dec stops at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= 8'd0;
        end else if (load) begin
            count <= value;
        end else if (dec && !zero) begin
            count <= count - 8'd1;
        end
    end

endmodule

/* common/phy_cfg_pkg.sv */
package phy_cfg_pkg;

    // lane and word geometry
    localparam int lane_count     = 4;
    localparam int beats_per_word = 8;
    localparam int pairs_per_word = beats_per_word / 2;  // one rise/fall pair per clk
    localparam int word_bits      = lane_count * beats_per_word;

    // delay line
    localparam int tap_count = 16;   // tap_sel is 4 bits

    // calibration
    localparam logic [word_bits-1:0] train_word = 32'hA5C3_5A3C;
    localparam int settle_cycles = 20;  // flush time after a tap change
    localparam int compare_words = 8;   // clean words needed to pass a tap

    // calibration FSM state codes
    localparam logic [2:0] st_idle    = 3'd0;
    localparam logic [2:0] st_settle  = 3'd1;
    localparam logic [2:0] st_compare = 3'd2;
    localparam logic [2:0] st_locked  = 3'd3;
    localparam logic [2:0] st_failed  = 3'd4;

endpackage

/* common/phy_data_pkg.sv */
package phy_data_pkg;

    import phy_cfg_pkg::*;

    // one sample across all lanes
    typedef logic [lane_count-1:0] nibble_t;

    // receive word, filled by beats and read flat
    // beat 7 is the first one received and sits in the top nibble
    typedef union packed {
        logic [word_bits-1:0]           word;
        nibble_t [beats_per_word-1:0]   beats;
    } rx_word_u;

endpackage

/* project.f */
common/phy_cfg_pkg.sv
common/phy_data_pkg.sv
rtl/tap_delay.sv
rtl/ddr_word_capture.sv
calib/train_counter.sv
calib/calib_fsm.sv
rtl/spi_ddr_phy.sv
verif/phy_checker.sv
verif/tb_spi_ddr_phy.sv

/* rtl/ddr_word_capture.sv */
`timescale 1ns/1ps

module ddr_word_capture import phy_cfg_pkg::*, phy_data_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  nibble_t  in_rise,
    input  nibble_t  in_fall,
    output rx_word_u word,
    output logic     word_valid
);

    logic [1:0] pair_cnt;    // free running, word boundary set by reset
    logic       last_pair;
    logic [2:0] rise_beat;
    logic [2:0] fall_beat;
    rx_word_u   shadow;
    rx_word_u   next_word;

    assign last_pair = (pair_cnt == 2'(pairs_per_word - 1));

    // pair 0 lands in beats 7/6, pair 3 in beats 1/0
    assign rise_beat = {~pair_cnt, 1'b1};
    assign fall_beat = {~pair_cnt, 1'b0};

    always_comb begin
        next_word = shadow;
        next_word.beats[rise_beat] = in_rise;  // rise sample comes first
        next_word.beats[fall_beat] = in_fall;
    end

    // assembly registers
    always_ff @(posedge clk) begin
        shadow <= next_word;
        if (last_pair) begin
            word <= next_word;  // includes the pair arriving this cycle
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pair_cnt   <= '0;
            word_valid <= 1'b0;
        end else begin
            pair_cnt   <= pair_cnt + 2'd1;
            word_valid <= last_pair;  // one cycle strobe every 4 clks
        end
    end

endmodule

/* rtl/spi_ddr_phy.sv */
`timescale 1ns/1ps

module spi_ddr_phy import phy_data_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cal_start,
    input  logic [3:0] delay_set,
    input  nibble_t    ddr_rise,
    input  nibble_t    ddr_fall,
    output rx_word_u   rx_data,
    output logic       rx_valid,
    output logic       delay_locked,
    output logic       cal_fail,
    output logic [3:0] tap_sel
);

    nibble_t    dly_rise;
    nibble_t    dly_fall;
    logic [3:0] cal_tap;
    logic       cal_active;
    logic       cnt_load;
    logic       cnt_dec;
    logic [7:0] cnt_value;
    logic       cnt_zero;

    // calibration owns the tap during a sweep and after lock
    assign tap_sel = cal_active ? cal_tap : delay_set;

    tap_delay u_tap_delay (
        .clk      (clk),
        .rst      (rst),
        .in_rise  (ddr_rise),
        .in_fall  (ddr_fall),
        .tap      (tap_sel),
        .out_rise (dly_rise),
        .out_fall (dly_fall)
    );

    ddr_word_capture u_capture (
        .clk        (clk),
        .rst        (rst),
        .in_rise    (dly_rise),
        .in_fall    (dly_fall),
        .word       (rx_data),
        .word_valid (rx_valid)
    );

    calib_fsm u_calib_fsm (
        .clk          (clk),
        .rst          (rst),
        .cal_start    (cal_start),
        .word         (rx_data),
        .word_valid   (rx_valid),
        .cnt_zero     (cnt_zero),
        .cnt_load     (cnt_load),
        .cnt_dec      (cnt_dec),
        .cnt_value    (cnt_value),
        .cal_tap      (cal_tap),
        .cal_active   (cal_active),
        .delay_locked (delay_locked),
        .cal_fail     (cal_fail)
    );

    train_counter u_train_counter (
        .clk   (clk),
        .rst   (rst),
        .load  (cnt_load),
        .value (cnt_value),
        .dec   (cnt_dec),
        .zero  (cnt_zero)
    );

endmodule

/* rtl/tap_delay.sv */
`timescale 1ns/1ps

module tap_delay import phy_cfg_pkg::*, phy_data_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  nibble_t    in_rise,
    input  nibble_t    in_fall,
    input  logic [3:0] tap,
    output nibble_t    out_rise,
    output nibble_t    out_fall
);

    nibble_t rise_q [1:tap_count-1];  // rise_q[k] holds the input from k cycles ago
    nibble_t fall_q [1:tap_count-1];
    nibble_t sel_rise;
    nibble_t sel_fall;

    // tap 0 takes the live pair, the output register supplies the base cycle
    always_comb begin
        if (tap == 4'd0) begin
            sel_rise = in_rise;
            sel_fall = in_fall;
        end else begin
            sel_rise = rise_q[tap];
            sel_fall = fall_q[tap];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < tap_count; i++) begin
                rise_q[i] <= '0;
                fall_q[i] <= '0;
            end
            out_rise <= '0;
            out_fall <= '0;
        end else begin
            rise_q[1] <= in_rise;
            fall_q[1] <= in_fall;
            for (int i = 2; i < tap_count; i++) begin
                rise_q[i] <= rise_q[i-1];
                fall_q[i] <= fall_q[i-1];
            end
            out_rise <= sel_rise;
            out_fall <= sel_fall;
        end
    end

endmodule

/* verif/phy_checker.sv */
`timescale 1ns/1ps

module phy_checker (
    input logic       clk,
    input logic       rst,
    input logic       rx_valid,
    input logic       delay_locked,
    input logic       cal_fail,
    input logic [3:0] tap_sel
);

    int assert_errors = 0;  // read by the testbench at the end of the run

    // one word every 4 cycles, so never two strobes back to back
    valid_spacing: assert property (@(posedge clk) disable iff (rst)
        rx_valid |=> !rx_valid)
        else begin
            $error("rx_valid high on two consecutive cycles");
            assert_errors++;
        end

    lock_fail_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(delay_locked && cal_fail))
        else begin
            $error("delay_locked and cal_fail high together");
            assert_errors++;
        end

    // a locked tap must not move
    locked_tap_stable: assert property (@(posedge clk) disable iff (rst)
        (delay_locked && $past(delay_locked)) |-> $stable(tap_sel))
        else begin
            $error("tap_sel changed while delay_locked was high");
            assert_errors++;
        end

endmodule

bind spi_ddr_phy phy_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .rx_valid     (rx_valid),
    .delay_locked (delay_locked),
    .cal_fail     (cal_fail),
    .tap_sel      (tap_sel)
);

/* verif/phy_stim.txt */
# drive <rise> <fall> | tap <t> | expect <word> | train <cycles> <offset> <word>
# cal lock <tap> | cal fail <tap_sel after failure>   (values hex, counts decimal)
# tap 0, first word after reset is partial and not checked
drive 0 0
drive 0 0
drive 0 0
drive 1 2
drive 3 4
drive 5 6
drive 7 8
expect 12345678
drive 8 7
drive 6 5
drive 4 3
drive 2 1
expect 87654321
# manual tap 2 shifts the stream by two pairs
tap 2
drive 0 0
drive 0 0
drive 9 a
drive b c
drive d e
drive f 0
expect 9abcdef0
drive 1 1
drive 2 2
drive 3 3
drive 4 4
expect 11223344
# training with offset 0 aligns at tap 3
train 8 0 a5c35a3c
cal lock 3
train 300 0 a5c35a3c
# second sweep, offset 2 aligns at tap 1
cal lock 1
train 300 2 a5c35a3c
# no tap can match, tap falls back to delay_set
cal fail 2
train 600 0 12345678

/* verif/tb_spi_ddr_phy.sv */
`timescale 1ns/1ps

module tb_spi_ddr_phy import phy_data_pkg::*; ();

    localparam string stim_path = "verif/phy_stim.txt";

    logic       clk;
    logic       rst;
    logic       cal_start;
    logic [3:0] delay_set;
    nibble_t    ddr_rise;
    nibble_t    ddr_fall;
    rx_word_u   rx_data;
    logic       rx_valid;
    logic       delay_locked;
    logic       cal_fail;
    logic [3:0] tap_sel;

    rx_word_u   expect_q[$];
    int         word_errors;
    int         tap_errors;
    int         other_errors;
    int         slot;          // pair index, 0 is the first pair after reset
    int         budget;        // watchdog length in cycles
    logic       cal_pending;
    logic       cal_expect_lock;
    logic [3:0] cal_expect_tap;

    spi_ddr_phy uut (
        .clk          (clk),
        .rst          (rst),
        .cal_start    (cal_start),
        .delay_set    (delay_set),
        .ddr_rise     (ddr_rise),
        .ddr_fall     (ddr_fall),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .delay_locked (delay_locked),
        .cal_fail     (cal_fail),
        .tap_sel      (tap_sel)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_word(input rx_word_u exp_word, input rx_word_u act_word);
        if (act_word.word !== exp_word.word) begin
            word_errors++;
            $display("mismatch at %0t ns: rx_data expected %h actual %h",
                     $time, exp_word.word, act_word.word);
        end
    endtask

    task automatic check_tap(input logic [3:0] exp_tap, input logic exp_lock,
                             input logic [3:0] act_tap, input logic act_lock);
        if (act_tap !== exp_tap) begin
            tap_errors++;
            $display("mismatch at %0t ns: tap_sel expected %0d actual %0d",
                     $time, exp_tap, act_tap);
        end
        if (act_lock !== exp_lock) begin
            tap_errors++;
            $display("mismatch at %0t ns: delay_locked expected %b actual %b",
                     $time, exp_lock, act_lock);
        end
    endtask

    // every input change happens 10 ns after the edge
    task automatic next_slot();
        @(posedge clk);
        #10;
        cal_start = 1'b0;  // start is a single-cycle pulse
        slot++;
    endtask

    task automatic drive_pair(input nibble_t rise, input nibble_t fall);
        ddr_rise = rise;
        ddr_fall = fall;
        next_slot();
    endtask

    // pattern pairs repeat with the pair index tied to the absolute slot
    task automatic drive_training(input int cycles, input int offset, input rx_word_u pattern);
        int k;
        logic [2:0] hi_beat;
        for (int i = 0; i < cycles; i++) begin
            k = (slot + offset) % 4;
            hi_beat = 3'(7 - 2 * k);
            drive_pair(pattern.beats[hi_beat], pattern.beats[hi_beat - 3'd1]);
        end
        if (cal_pending) begin
            other_errors++;
            $display("calibration did not finish within the training stream");
        end
    endtask

    task automatic arm_calibration(input logic lock, input logic [3:0] tap);
        if (cal_pending) begin
            other_errors++;
            $display("calibration started before the previous one finished");
        end
        cal_expect_lock = lock;
        cal_expect_tap  = tap;
        cal_pending     = 1'b1;
        cal_start       = 1'b1;
    endtask

    // outputs settle after the rising edge, so look at them on the falling edge
    always @(negedge clk) begin
        if (!rst && rx_valid && expect_q.size() > 0) begin
            check_word(expect_q.pop_front(), rx_data);
        end
        if (cal_pending && !cal_start && (delay_locked || cal_fail)) begin
            if (cal_expect_lock && !delay_locked) begin
                other_errors++;
                $display("calibration failed where a lock on tap %0d was expected",
                         cal_expect_tap);
            end else if (!cal_expect_lock && !cal_fail) begin
                other_errors++;
                $display("calibration locked where a failure was expected");
            end
            check_tap(cal_expect_tap, cal_expect_lock, tap_sel, delay_locked);
            cal_pending = 1'b0;
        end
    end

    function automatic int count_budget(input int fd);
        string line;
        string kind;
        int    cycles;
        int    total;
        total = 10;  // reset and drain
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%s", kind) < 1) continue;
            if (kind == "drive") total += 1;
            if (kind == "cal") total += 1000;
            if (kind == "train" && $sscanf(line, "%s %d", kind, cycles) == 2) begin
                total += cycles;
            end
        end
        return total;
    endfunction

    task automatic run_records(input int fd);
        string      line;
        string      kind;
        string      mode;
        int         cycles;
        int         offset;
        logic [3:0] r;
        logic [3:0] f;
        logic [31:0] w;
        rx_word_u   u;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%s", kind) < 1 || kind.substr(0, 0) == "#") continue;
            case (kind)
                "tap": begin
                    void'($sscanf(line, "%s %h", kind, r));
                    delay_set = r;
                end
                "drive": begin
                    void'($sscanf(line, "%s %h %h", kind, r, f));
                    drive_pair(r, f);
                end
                "train": begin
                    void'($sscanf(line, "%s %d %d %h", kind, cycles, offset, w));
                    u.word = w;
                    drive_training(cycles, offset, u);
                end
                "expect": begin
                    void'($sscanf(line, "%s %h", kind, w));
                    u.word = w;
                    expect_q.push_back(u);
                end
                "cal": begin
                    void'($sscanf(line, "%s %s %h", kind, mode, r));
                    arm_calibration(mode == "lock", r);
                end
                default: begin
                    other_errors++;
                    $display("unknown record %s in stimulus file", kind);
                end
            endcase
        end
    endtask

    task automatic drain_expected();
        for (int i = 0; i < 12 && expect_q.size() > 0; i++) begin
            @(negedge clk);
        end
        if (expect_q.size() > 0) begin
            other_errors++;
            $display("%0d expected words never arrived", expect_q.size());
        end
        if (cal_pending) begin
            other_errors++;
            $display("calibration still running at the end of the stimulus");
        end
    endtask

    initial begin
        wait (budget > 0);
        repeat (budget) @(posedge clk);
        $display("watchdog expired after %0d cycles, test did not finish", budget);
        $display("Simulation failed");
        $finish;
    end

    initial begin : main
        int fd;
        int total;
        rst          = 1'b1;
        cal_start    = 1'b0;
        delay_set    = 4'd0;
        ddr_rise     = '0;
        ddr_fall     = '0;
        word_errors  = 0;
        tap_errors   = 0;
        other_errors = 0;
        slot         = 0;
        cal_pending  = 1'b0;
        fd = $fopen(stim_path, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", stim_path);
            $display("Simulation failed");
            $finish;
        end else begin
            budget = count_budget(fd);
            $fclose(fd);
            repeat (3) @(posedge clk);
            #10;
            rst = 1'b0;
            fd = $fopen(stim_path, "r");
            run_records(fd);
            $fclose(fd);
            drain_expected();
            total = word_errors + tap_errors + other_errors + uut.u_checker.assert_errors;
            $display("errors: words %0d, taps %0d, other %0d, assertions %0d",
                     word_errors, tap_errors, other_errors, uut.u_checker.assert_errors);
            if (total == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule
